// File: include/dma_defs.svh
//##########################################################
// DMA endpoint configuration constants
// Base address, datapath widths, register depth and the
// bus read timing shared by the package and the RTL
//##########################################################

`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Absolute bus address of offset 0 (channel-count register)
`define DMA_BASE_ADDRESS 32'h43c00000

// Width of one register-file word
`define DMA_DATA_WIDTH 32

// Register index width, 256 registers
`define DMA_REG_ADDR_WIDTH 8

// Extra cycles a bus read completion is held off
`define DMA_PULSE_STRETCH 6

// Bus reads return only the low 16 bits when set
`define DMA_LEGACY_READ 0

`endif

// File: hw/dma_pkg.sv
//##########################################################
// DMA subsystem types
// Vector types for bus, register file and channel count,
// plus the endpoint FSM state encoding
//##########################################################

`include "dma_defs.svh"

package dma_pkg;

    // Bus side
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // Register-file side
    typedef logic [`DMA_DATA_WIDTH-1:0]     reg_data_t;
    typedef logic [`DMA_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Number of active channels, written by the host
    typedef logic [7:0] chan_count_t;

    // Endpoint FSM
    typedef enum logic [2:0] {
        idle         = 3'b000,
        act_write    = 3'b001,
        wait_read    = 3'b010,
        act_read     = 3'b011,
        read_stretch = 3'b100
    } endpoint_state_t;

endpackage

// File: hw/core_reg_file.sv
//##########################################################
// Core data register file
// One synchronous write port and two registered read
// ports, one for the DMA endpoint and one for the core
//##########################################################

`timescale 1ns/100ps
`include "dma_defs.svh"

module core_reg_file (
    input  logic              clock,
    input  logic              reset,
    // Write port, owned by the endpoint
    input  dma_pkg::reg_addr_t write_addr,
    input  dma_pkg::reg_data_t write_data,
    input  logic              write_valid,
    // Endpoint read port
    input  dma_pkg::reg_addr_t read_addr,
    output dma_pkg::reg_data_t read_data,
    // Processor core read port
    input  dma_pkg::reg_addr_t core_read_addr,
    output dma_pkg::reg_data_t core_read_data
);
    import dma_pkg::*;

    localparam int reg_depth = 1 << `DMA_REG_ADDR_WIDTH;

    reg_data_t mem [reg_depth];

    // Registers start out cleared
    initial begin
        for (int i = 0; i < reg_depth; i++) begin
            mem[i] = '0;
        end
    end

    // Single write port
    always_ff @(posedge clock) begin
        if (write_valid) begin
            mem[write_addr] <= write_data;
        end
    end

    // Endpoint read, one cycle latency
    // Same-cycle write to the same address returns the old word
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            read_data <= '0;
        end else begin
            read_data <= mem[read_addr];
        end
    end

    // Core read, same timing as the endpoint port
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            core_read_data <= '0;
        end else begin
            core_read_data <= mem[core_read_addr];
        end
    end

endmodule

// File: hw/dma_endpoint.sv
//##########################################################
// DMA bus endpoint
// Decodes base-relative bus accesses, holds the channel
// count and merges stream writes onto the single
// register-file write port, stream taking priority
//##########################################################

`timescale 1ns/100ps
`include "dma_defs.svh"

module dma_endpoint #(
    parameter bit legacy_read = `DMA_LEGACY_READ
) (
    input  logic                 clock,
    input  logic                 reset,
    // Bus slave
    input  dma_pkg::bus_addr_t   bus_address,
    input  dma_pkg::bus_data_t   bus_write_data,
    input  logic                 bus_write_strobe,
    input  logic                 bus_read_strobe,
    output dma_pkg::bus_data_t   bus_read_data,
    output logic                 bus_ready,
    // Stream input, no back-pressure
    input  logic                 stream_valid,
    input  dma_pkg::reg_addr_t   stream_dest,
    input  dma_pkg::reg_data_t   stream_data,
    // Register file
    output dma_pkg::reg_addr_t   reg_write_addr,
    output dma_pkg::reg_data_t   reg_write_data,
    output logic                 reg_write_valid,
    output dma_pkg::reg_addr_t   reg_read_addr,
    input  dma_pkg::reg_data_t   reg_read_data,
    // Channel-count register
    output dma_pkg::chan_count_t n_channels
);
    import dma_pkg::*;

    localparam bus_addr_t base_address = `DMA_BASE_ADDRESS;
    localparam bus_addr_t reg_base_offset = bus_addr_t'(4);
    localparam int stretch_width = $clog2(`DMA_PULSE_STRETCH + 1);
    localparam logic [stretch_width-1:0] stretch_load = stretch_width'(`DMA_PULSE_STRETCH);

    endpoint_state_t state;

    // Decode of the incoming access
    bus_addr_t bus_offset;
    bus_addr_t read_offset;
    logic      offset_is_count;

    // Shadow of the accepted bus write
    bus_addr_t latched_offset;
    bus_data_t latched_data;
    bus_addr_t write_offset;
    logic      write_is_count;

    logic write_done;
    logic write_step;
    logic bus_issue;
    logic read_is_count;
    logic [stretch_width-1:0] stretch_count;
    bus_data_t read_word;

    assign bus_offset      = bus_address - base_address;
    assign read_offset     = bus_offset - reg_base_offset;
    assign offset_is_count = bus_offset < reg_base_offset;

    assign write_offset   = latched_offset - reg_base_offset;
    assign write_is_count = latched_offset < reg_base_offset;

    // Shadowed write acts once, a register write only while the stream is quiet
    assign write_step = (state == act_write) && !write_done &&
                        (write_is_count || !stream_valid);
    assign bus_issue  = write_step && !write_is_count;

    // Word returned on the bus for the current read
    always_comb begin
        if (read_is_count) begin
            read_word = bus_data_t'(n_channels);
        end else if (legacy_read) begin
            read_word = {16'b0, reg_read_data[15:0]};
        end else begin
            read_word = bus_data_t'(reg_read_data);
        end
    end

    // Endpoint FSM
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state         <= idle;
            bus_ready     <= 1'b1;
            write_done    <= 1'b0;
            read_is_count <= 1'b0;
            stretch_count <= '0;
            n_channels    <= '0;
        end else begin
            case (state)
                idle: begin
                    if (bus_write_strobe) begin
                        state     <= act_write;
                        bus_ready <= 1'b0;
                    end else if (bus_read_strobe) begin
                        state         <= wait_read;
                        bus_ready     <= 1'b0;
                        read_is_count <= offset_is_count;
                    end
                end
                act_write: begin
                    if (write_done) begin
                        state      <= idle;
                        bus_ready  <= 1'b1;
                        write_done <= 1'b0;
                    end else if (write_step) begin
                        write_done <= 1'b1;
                        if (write_is_count) begin
                            n_channels <= latched_data[7:0];
                        end
                    end
                end
                // Register file read in flight
                wait_read: begin
                    state <= act_read;
                end
                act_read: begin
                    state         <= read_stretch;
                    stretch_count <= stretch_load;
                end
                // Hold completion off for the stretch length
                read_stretch: begin
                    if (stretch_count == '0) begin
                        state     <= idle;
                        bus_ready <= 1'b1;
                    end else begin
                        stretch_count <= stretch_count - 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Write port strobe, stream or deferred bus write
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            reg_write_valid <= 1'b0;
        end else begin
            reg_write_valid <= stream_valid || bus_issue;
        end
    end

    // Bus write shadow
    always_ff @(posedge clock) begin
        if (state == idle && bus_write_strobe) begin
            latched_offset <= bus_offset;
            latched_data   <= bus_write_data;
        end
    end

    // Write port payload, stream first
    always_ff @(posedge clock) begin
        if (stream_valid) begin
            reg_write_addr <= stream_dest;
            reg_write_data <= stream_data;
        end else if (bus_issue) begin
            reg_write_addr <= write_offset[`DMA_REG_ADDR_WIDTH+1:2];
            reg_write_data <= reg_data_t'(latched_data);
        end
    end

    // Read index and captured read word
    always_ff @(posedge clock) begin
        if (state == idle && bus_read_strobe && !bus_write_strobe) begin
            if (offset_is_count) begin
                reg_read_addr <= '0;
            end else begin
                reg_read_addr <= read_offset[`DMA_REG_ADDR_WIDTH+1:2];
            end
        end
        if (state == act_read) begin
            bus_read_data <= read_word;
        end
    end

endmodule

// File: hw/dma_subsystem_top.sv
//##########################################################
// DMA subsystem top level
// Endpoint plus core register file, with the core read
// port and channel count brought out
//##########################################################

`timescale 1ns/100ps

module dma_subsystem_top (
    input  logic                 clock,
    input  logic                 reset,
    // Host bus
    input  dma_pkg::bus_addr_t   bus_address,
    input  dma_pkg::bus_data_t   bus_write_data,
    input  logic                 bus_write_strobe,
    input  logic                 bus_read_strobe,
    output dma_pkg::bus_data_t   bus_read_data,
    output logic                 bus_ready,
    // Sample stream
    input  logic                 stream_valid,
    input  dma_pkg::reg_addr_t   stream_dest,
    input  dma_pkg::reg_data_t   stream_data,
    // Processor core read port
    input  dma_pkg::reg_addr_t   core_read_addr,
    output dma_pkg::reg_data_t   core_read_data,
    // Channel count for the core
    output dma_pkg::chan_count_t n_channels
);
    import dma_pkg::*;

    // Endpoint to register file
    reg_addr_t reg_write_addr;
    reg_data_t reg_write_data;
    logic      reg_write_valid;
    reg_addr_t reg_read_addr;
    reg_data_t reg_read_data;

    dma_endpoint i_endpoint (
        .clock            (clock),
        .reset            (reset),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_strobe (bus_write_strobe),
        .bus_read_strobe  (bus_read_strobe),
        .bus_read_data    (bus_read_data),
        .bus_ready        (bus_ready),
        .stream_valid     (stream_valid),
        .stream_dest      (stream_dest),
        .stream_data      (stream_data),
        .reg_write_addr   (reg_write_addr),
        .reg_write_data   (reg_write_data),
        .reg_write_valid  (reg_write_valid),
        .reg_read_addr    (reg_read_addr),
        .reg_read_data    (reg_read_data),
        .n_channels       (n_channels)
    );

    core_reg_file i_reg_file (
        .clock          (clock),
        .reset          (reset),
        .write_addr     (reg_write_addr),
        .write_data     (reg_write_data),
        .write_valid    (reg_write_valid),
        .read_addr      (reg_read_addr),
        .read_data      (reg_read_data),
        .core_read_addr (core_read_addr),
        .core_read_data (core_read_data)
    );

endmodule

// File: sim/dma_subsystem_chk.sv
//##########################################################
// DMA subsystem protocol checker
// Ready out of reset, strobe discipline, fixed read
// latency and channel-count updates
//##########################################################

`timescale 1ns/100ps
`include "dma_defs.svh"

module dma_subsystem_chk (
    input logic                 clock,
    input logic                 reset,
    input dma_pkg::bus_addr_t   bus_address,
    input logic                 bus_write_strobe,
    input logic                 bus_read_strobe,
    input logic                 bus_ready,
    input dma_pkg::chan_count_t n_channels
);
    import dma_pkg::*;

    bus_addr_t bus_offset;
    logic      count_write;

    // Offsets below the first register hit the channel count
    assign bus_offset  = bus_address - bus_addr_t'(`DMA_BASE_ADDRESS);
    assign count_write = bus_write_strobe && (bus_offset < bus_addr_t'(4));

    ready_after_reset: assert property (@(posedge clock) $rose(reset) |-> bus_ready)
        else $error("bus_ready low when reset was released");

    strobe_while_ready: assert property (@(posedge clock) disable iff (!reset)
        !bus_ready |-> !bus_write_strobe && !bus_read_strobe)
        else $error("bus strobe issued while bus_ready was low");

    // Ready low from the strobe edge for 3 + stretch cycles
    read_latency: assert property (@(posedge clock) disable iff (!reset)
        bus_read_strobe && !bus_write_strobe && bus_ready
        |=> !bus_ready ##(`DMA_PULSE_STRETCH + 2) !bus_ready ##1 bus_ready)
        else $error("bus read did not complete after the fixed latency");

    count_update: assert property (@(posedge clock) disable iff (!reset)
        (n_channels != $past(n_channels)) |-> $past(count_write, 2))
        else $error("n_channels changed without a write to offset 0");

endmodule

bind dma_subsystem_top dma_subsystem_chk i_chk (.*);

// File: sim/dma_subsystem_tb.sv
//##########################################################
// DMA subsystem testbench
// Seeded random bus and stream traffic checked against
// a register and channel-count model
//##########################################################

`timescale 1ns/100ps
`include "dma_defs.svh"

module dma_subsystem_tb;
    import dma_pkg::*;

    localparam int clock_period  = 40;
    localparam int drive_delay   = 5;
    localparam int ready_timeout = 64;
    localparam int read_cycles   = 3 + `DMA_PULSE_STRETCH;
    localparam int reg_depth     = 1 << `DMA_REG_ADDR_WIDTH;
    localparam bus_addr_t base_address = `DMA_BASE_ADDRESS;

    logic        clock;
    logic        reset;
    bus_addr_t   bus_address;
    bus_data_t   bus_write_data;
    logic        bus_write_strobe;
    logic        bus_read_strobe;
    bus_data_t   bus_read_data;
    logic        bus_ready;
    logic        stream_valid;
    reg_addr_t   stream_dest;
    reg_data_t   stream_data;
    reg_addr_t   core_read_addr;
    reg_data_t   core_read_data;
    chan_count_t n_channels;

    // Reference model
    reg_data_t   model_mem [reg_depth];
    chan_count_t model_count;

    integer seed;
    int     error_count;
    int     check_count;
    int     test_count;
    int     failed_tests;
    int     test_start_errors;

    dma_subsystem_top i_dut (
        .clock            (clock),
        .reset            (reset),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_strobe (bus_write_strobe),
        .bus_read_strobe  (bus_read_strobe),
        .bus_read_data    (bus_read_data),
        .bus_ready        (bus_ready),
        .stream_valid     (stream_valid),
        .stream_dest      (stream_dest),
        .stream_data      (stream_data),
        .core_read_addr   (core_read_addr),
        .core_read_data   (core_read_data),
        .n_channels       (n_channels)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic finish_test(input string name);
        int errors;
        errors = error_count - test_start_errors;
        test_count++;
        if (errors == 0) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: %0d errors", test_count, name, errors);
        end
        test_start_errors = error_count;
    endtask

    // Polls once per cycle, gives up after ready_timeout cycles
    task automatic wait_ready(output int cycles);
        cycles = 0;
        while (bus_ready !== 1'b1 && cycles < ready_timeout) begin
            @(posedge clock);
            #drive_delay;
            cycles++;
        end
        if (bus_ready !== 1'b1) begin
            error_count++;
            $display("Timeout: bus_ready stayed low for %0d cycles", cycles);
        end
    endtask

    function automatic bus_addr_t reg_address(input reg_addr_t index);
        return base_address + bus_addr_t'(4) + (bus_addr_t'(index) << 2);
    endfunction

    // Word as the bus returns it, low half only in legacy mode
    function automatic bus_data_t read_view(input reg_data_t word);
        if (`DMA_LEGACY_READ) begin
            return {16'b0, word[15:0]};
        end
        return bus_data_t'(word);
    endfunction

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        int cycles;
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_strobe = 1'b1;
        @(posedge clock);
        #drive_delay;
        bus_write_strobe = 1'b0;
        wait_ready(cycles);
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        int cycles;
        bus_address     = addr;
        bus_read_strobe = 1'b1;
        @(posedge clock);
        #drive_delay;
        bus_read_strobe = 1'b0;
        wait_ready(cycles);
        check_value("bus read latency", 32'(cycles), 32'(read_cycles));
        data = bus_read_data;
    endtask

    task automatic core_read(input reg_addr_t addr, output reg_data_t data);
        core_read_addr = addr;
        @(posedge clock);
        #drive_delay;
        data = core_read_data;
    endtask

    initial begin
        reg_addr_t idx;
        reg_addr_t dest;
        bus_data_t data;
        bus_data_t word;
        reg_data_t got;
        int        burst;
        int        cycles;
        logic      pending;
        reg_data_t expected;
        logic      hist_valid [2];
        reg_addr_t hist_dest [2];
        reg_data_t hist_data [2];

        seed              = 32'h6666e775;
        error_count       = 0;
        check_count       = 0;
        test_count        = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        reset             = 1'b0;
        bus_address       = '0;
        bus_write_data    = '0;
        bus_write_strobe  = 1'b0;
        bus_read_strobe   = 1'b0;
        stream_valid      = 1'b0;
        stream_dest       = '0;
        stream_data       = '0;
        core_read_addr    = '0;
        model_count       = '0;
        for (int i = 0; i < reg_depth; i++) begin
            model_mem[i] = '0;
        end
        repeat (4) @(posedge clock);
        #drive_delay;
        reset = 1'b1;

        check_value("bus_ready", 32'(bus_ready), 32'd1);
        check_value("n_channels", 32'(n_channels), 32'd0);
        for (int n = 0; n < 8; n++) begin
            core_read(reg_addr_t'($random(seed)), got);
            check_value("core_read_data", got, 32'd0);
        end
        finish_test("reset state");

        for (int n = 0; n < 16; n++) begin
            idx  = reg_addr_t'($random(seed));
            data = bus_data_t'($random(seed));
            bus_write(reg_address(idx), data);
            model_mem[idx] = reg_data_t'(data);
            core_read(idx, got);
            check_value("core_read_data", got, model_mem[idx]);
        end
        finish_test("bus write");

        // Each stream word is read back two cycles after it is driven
        hist_valid[0] = 1'b0;
        hist_valid[1] = 1'b0;
        pending       = 1'b0;
        expected      = '0;
        for (int i = 0; i < 43; i++) begin
            if (pending) begin
                check_value("core_read_data", core_read_data, expected);
            end
            pending  = hist_valid[1];
            expected = hist_data[1];
            if (hist_valid[1]) begin
                core_read_addr = hist_dest[1];
            end
            hist_valid[1] = hist_valid[0];
            hist_dest[1]  = hist_dest[0];
            hist_data[1]  = hist_data[0];
            hist_valid[0] = (i < 40) && ($random(seed) % 4 != 0);
            hist_dest[0]  = reg_addr_t'($random(seed));
            hist_data[0]  = reg_data_t'($random(seed));
            stream_valid  = hist_valid[0];
            stream_dest   = hist_dest[0];
            stream_data   = hist_data[0];
            if (hist_valid[0]) begin
                model_mem[hist_dest[0]] = hist_data[0];
            end
            @(posedge clock);
            #drive_delay;
        end
        stream_valid = 1'b0;
        finish_test("stream write");

        for (int n = 0; n < 16; n++) begin
            idx = reg_addr_t'($random(seed));
            bus_read(reg_address(idx), word);
            check_value("bus_read_data", word, read_view(model_mem[idx]));
        end
        finish_test("bus read");

        for (int n = 0; n < 4; n++) begin
            data = bus_data_t'($random(seed));
            bus_write(base_address, data);
            model_count = data[7:0];
            check_value("n_channels", 32'(n_channels), 32'(model_count));
            bus_read(base_address, word);
            check_value("bus_read_data", word, 32'(model_count));
        end
        finish_test("channel count");

        // Bus write deferred behind a stream burst to a small address range
        for (int round = 0; round < 8; round++) begin
            idx              = reg_addr_t'($random(seed) & 7);
            data             = bus_data_t'($random(seed));
            burst            = 1 + ($random(seed) & 7);
            bus_address      = reg_address(idx);
            bus_write_data   = data;
            bus_write_strobe = 1'b1;
            for (int k = 0; k < burst; k++) begin
                dest         = reg_addr_t'($random(seed) & 7);
                word         = bus_data_t'($random(seed));
                stream_valid = 1'b1;
                stream_dest  = dest;
                stream_data  = reg_data_t'(word);
                model_mem[dest] = reg_data_t'(word);
                @(posedge clock);
                #drive_delay;
                bus_write_strobe = 1'b0;
            end
            stream_valid   = 1'b0;
            model_mem[idx] = reg_data_t'(data);
            wait_ready(cycles);
            for (int r = 0; r < 8; r++) begin
                core_read(reg_addr_t'(r), got);
                check_value("core_read_data", got, model_mem[r]);
            end
        end
        finish_test("bus and stream");

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
hw/dma_pkg.sv
hw/core_reg_file.sv
hw/dma_endpoint.sv
hw/dma_subsystem_top.sv
sim/dma_subsystem_chk.sv
sim/dma_subsystem_tb.sv

// File: Makefile
# Verilator build for the DMA subsystem testbench

VERILATOR = verilator
FLAGS     = --timing --assert -Wno-fatal
TOP       = dma_subsystem_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
